// File: logic/ia_loader_macros.svh
`ifndef IA_LOADER_MACROS_SVH
`define IA_LOADER_MACROS_SVH

// array geometry
`define IA_SIZE       16
`define IA_SIZE_LOG2  4

// element and register widths
`define IA_DATA_W     16  // one element sent to the array
`define IA_REG_W      32  // config fields and addresses

// ICB read side, 32-bit bus only
`define IA_BUS_W      32
`define IA_BEAT_BYTES 4
`define IA_LEN_W      4   // burst length minus one

`endif

// File: logic/ia_loader_pkg.sv
`default_nettype none
`include "ia_loader_macros.svh"

package ia_loader_pkg;

    typedef logic signed [7:0]            s8_t;
    typedef logic signed [`IA_DATA_W-1:0] ia_elem_t;
    typedef ia_elem_t [`IA_SIZE-1:0]      ia_row_t;   // element 0 in the low bits
    typedef ia_elem_t [`IA_BEAT_BYTES-1:0] ia_lanes_t; // unpacked beat, one lane per byte slot

    // raw config as presented with init_cfg
    typedef struct packed {
        logic [`IA_REG_W-1:0]        k;           // ia rows
        logic [`IA_REG_W-1:0]        n;           // ia cols
        logic [`IA_REG_W-1:0]        m;           // oa cols, sets the sweep repeat count
        logic [`IA_REG_W-1:0]        base;
        logic [`IA_REG_W-1:0]        stride;      // bytes between matrix rows
        logic signed [`IA_REG_W-1:0] zp;
        logic                        use_16bits;  // 1 = s16, 0 = s8
    } ia_cfg_t;

    // current tile, as seen by the loader datapath
    typedef struct packed {
        logic [`IA_SIZE_LOG2:0]      valid_rows;  // 1..SIZE
        logic [`IA_LEN_W-1:0]        beats;       // per row
        logic [`IA_REG_W-1:0]        addr;
        logic [`IA_REG_W-1:0]        stride;
        logic signed [`IA_REG_W-1:0] zp;
        logic                        use_16bits;
        logic                        first_col;
        logic                        last_col;
        logic                        last_tile;
    } tile_info_t;

    typedef struct packed {
        logic [`IA_REG_W-1:0] addr;
        logic [`IA_LEN_W-1:0] len;  // beats - 1
    } icb_cmd_t;

    // one response beat, read as s8 or s16 lanes
    typedef union packed {
        s8_t [`IA_BEAT_BYTES-1:0]        s8;
        ia_elem_t [`IA_BEAT_BYTES/2-1:0] s16;
    } rsp_word_u;

endpackage

`default_nettype wire

// File: logic/ia_loader_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module ia_loader_fsm
    import ia_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_cfg,
    input  logic       load_ia_granted,
    input  logic       send_ia_trigger,
    input  logic       tile_loaded,
    input  logic       ia_sending_done,
    input  tile_info_t tile_info,
    output logic       idle,
    output logic       load_ia_req,
    output logic       load_en,
    output logic       send_start,
    output logic       ia_data_valid
);

    typedef enum logic [1:0] {IDLE, REQ, LOAD, SEND} state_t;

    state_t state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (init_cfg) state <= REQ;
                REQ:  if (load_ia_granted) state <= LOAD;  // grant only counts here
                LOAD: if (tile_loaded) state <= SEND;
                SEND: begin
                    // walker steps on the same edge, so last_tile is still this tile
                    if (ia_sending_done) state <= tile_info.last_tile ? IDLE : REQ;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // tile ready flag, dropped one cycle after the trigger is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ia_data_valid <= 1'b0;
        end else if (state == LOAD && tile_loaded) begin
            ia_data_valid <= 1'b1;
        end else if (send_start) begin
            ia_data_valid <= 1'b0;
        end
    end

    assign idle        = (state == IDLE);
    assign load_ia_req = (state == REQ);
    assign load_en     = (state == LOAD);  // held for the whole load
    assign send_start  = (state == SEND) && ia_data_valid && send_ia_trigger;

endmodule

`default_nettype wire

// File: logic/tile_walker.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module tile_walker
    import ia_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       init_cfg,
    input  logic       idle,
    input  ia_cfg_t    cfg,
    input  logic       ia_sending_done,
    output tile_info_t tile_info
);

    localparam logic [`IA_REG_W-1:0]     ROUND   = `IA_SIZE - 1;
    localparam logic [`IA_REG_W-1:0]     STEP_S8 = `IA_SIZE;      // bytes per tile row
    localparam logic [`IA_REG_W-1:0]     STEP_16 = 2 * `IA_SIZE;
    localparam logic [`IA_SIZE_LOG2:0]   FULL    = `IA_SIZE;

    logic                        load_cfg;
    logic [`IA_REG_W-1:0]        tiles_k, tiles_n, tiles_m;  // ceilings, combinational
    logic [`IA_REG_W-1:0]        pad_k, pad_n;
    logic [`IA_REG_W-1:0]        row_tiles, col_tiles, loops; // latched counts
    logic [`IA_SIZE_LOG2-1:0]    row_rem, col_rem;            // unused cols / rows of edge tiles
    logic [`IA_REG_W-1:0]        stride;
    logic signed [`IA_REG_W-1:0] zp;
    logic                        use_16bits;
    logic [`IA_REG_W-1:0]        col_idx, loop_cnt, row_idx;
    logic [`IA_REG_W-1:0]        row_base, tile_addr;
    logic                        last_col, last_loop, last_row;
    logic [`IA_SIZE_LOG2:0]      valid_cols, beats_w;

    assign load_cfg = init_cfg && idle;

    // ceil and pad by shift and add
    always_comb begin
        tiles_k = (cfg.k + ROUND) >> `IA_SIZE_LOG2;
        tiles_n = (cfg.n + ROUND) >> `IA_SIZE_LOG2;
        tiles_m = (cfg.m + ROUND) >> `IA_SIZE_LOG2;
        pad_k   = (tiles_k << `IA_SIZE_LOG2) - cfg.k;
        pad_n   = (tiles_n << `IA_SIZE_LOG2) - cfg.n;
    end

    always_ff @(posedge clk) begin
        if (load_cfg) begin
            row_tiles  <= tiles_n;
            col_tiles  <= tiles_k;
            loops      <= tiles_m;
            row_rem    <= pad_n[`IA_SIZE_LOG2-1:0];
            col_rem    <= pad_k[`IA_SIZE_LOG2-1:0];
            stride     <= cfg.stride;
            zp         <= cfg.zp;
            use_16bits <= cfg.use_16bits;
        end
    end

    // ==================================================================
    // tile stepping: column, then sweep repeat, then tile row
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_idx   <= '0;
            loop_cnt  <= '0;
            row_idx   <= '0;
            row_base  <= '0;
            tile_addr <= '0;
        end else if (load_cfg) begin
            col_idx   <= '0;
            loop_cnt  <= '0;
            row_idx   <= '0;
            row_base  <= cfg.base;
            tile_addr <= cfg.base;
        end else if (ia_sending_done) begin
            if (!last_col) begin
                col_idx   <= col_idx + 1'b1;
                tile_addr <= tile_addr + (use_16bits ? STEP_16 : STEP_S8);
            end else if (!last_loop) begin
                col_idx   <= '0;
                loop_cnt  <= loop_cnt + 1'b1;
                tile_addr <= row_base;             // sweep the same row again
            end else begin
                col_idx   <= '0;
                loop_cnt  <= '0;
                row_idx   <= row_idx + 1'b1;
                row_base  <= row_base + (stride << `IA_SIZE_LOG2);
                tile_addr <= row_base + (stride << `IA_SIZE_LOG2);
            end
        end
    end

    assign last_col   = (col_idx == row_tiles - 1'b1);
    assign last_loop  = (loop_cnt == loops - 1'b1);
    assign last_row   = (row_idx == col_tiles - 1'b1);
    assign valid_cols = last_col ? FULL - {1'b0, row_rem} : FULL;
    assign beats_w    = use_16bits ? (valid_cols + 5'd1) >> 1 : (valid_cols + 5'd3) >> 2;

    always_comb begin
        tile_info.valid_rows = last_row ? FULL - {1'b0, col_rem} : FULL;
        tile_info.beats      = beats_w[`IA_LEN_W-1:0];
        tile_info.addr       = tile_addr;
        tile_info.stride     = stride;
        tile_info.zp         = zp;
        tile_info.use_16bits = use_16bits;
        tile_info.first_col  = (col_idx == '0);
        tile_info.last_col   = last_col;
        tile_info.last_tile  = last_col && last_loop && last_row;
    end

endmodule

`default_nettype wire

// File: logic/icb_read_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module icb_read_master
    import ia_loader_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       load_en,
    input  tile_info_t tile_info,
    input  logic       icb_cmd_ready,
    output logic       icb_cmd_valid,
    output icb_cmd_t   icb_cmd
);

    logic [`IA_SIZE_LOG2:0] row_cnt;   // rows put on the bus so far
    logic [`IA_REG_W-1:0]   row_addr;
    logic                   more_rows;

    assign more_rows = (row_cnt < tile_info.valid_rows);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_cmd_valid <= 1'b0;
            row_cnt       <= '0;
            row_addr      <= '0;
        end else if (!load_en) begin
            icb_cmd_valid <= 1'b0;
            row_cnt       <= '0;
            row_addr      <= tile_info.addr;  // first row of the next tile
        end else if (!icb_cmd_valid || icb_cmd_ready) begin
            // slot free, either idle or the held command just went
            if (icb_cmd_valid) row_addr <= row_addr + tile_info.stride;
            icb_cmd_valid <= more_rows;
            if (more_rows) row_cnt <= row_cnt + 1'b1;
        end
    end

    assign icb_cmd.addr = row_addr;
    assign icb_cmd.len  = tile_info.beats - 1'b1;  // same length for every row of a tile

endmodule

`default_nettype wire

// File: logic/rsp_unpacker.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module rsp_unpacker
    import ia_loader_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load_en,
    input  logic                        cfg_zp_16,      // element width, s16 when high
    input  logic signed [`IA_REG_W-1:0] zp,
    input  tile_info_t                  tile_info,
    input  logic                        icb_rsp_valid,
    input  rsp_word_u                   icb_rsp_rdata,
    output logic                        icb_rsp_ready,
    output logic                        wr_en,
    output logic [`IA_SIZE_LOG2-1:0]    wr_row,
    output logic [`IA_SIZE_LOG2-1:0]    wr_col,
    output ia_lanes_t                   wr_data,
    output logic [`IA_BEAT_BYTES-1:0]   wr_mask,
    output logic                        tile_loaded
);

    localparam logic signed [`IA_REG_W:0] MAX16 = 33'sd32767;
    localparam logic signed [`IA_REG_W:0] MIN16 = -33'sd32768;

    logic                      rsp_hs;
    logic                      last_beat, last_row;
    logic [`IA_LEN_W-1:0]      beat_cnt;
    logic [`IA_SIZE_LOG2-1:0]  row_cnt;

    // ==================================================================
    // beat and row position inside the tile
    // ==================================================================
    assign icb_rsp_ready = load_en;
    assign rsp_hs        = icb_rsp_valid && icb_rsp_ready;
    assign last_beat     = (beat_cnt == tile_info.beats - 1'b1);
    assign last_row      = ({1'b0, row_cnt} == tile_info.valid_rows - 1'b1);
    assign tile_loaded   = rsp_hs && last_beat && last_row;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (!load_en) begin
            beat_cnt <= '0;
            row_cnt  <= '0;
        end else if (rsp_hs) begin
            if (last_beat) begin
                beat_cnt <= '0;
                row_cnt  <= last_row ? '0 : row_cnt + 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // ==================================================================
    // lane decode, zero point, saturate
    // ==================================================================
    assign wr_en  = rsp_hs;
    assign wr_row = row_cnt;
    assign wr_col = cfg_zp_16 ? {beat_cnt[2:0], 1'b0} : {beat_cnt[1:0], 2'b00};

    always_comb begin
        for (int i = 0; i < `IA_BEAT_BYTES; i++) begin
            ia_elem_t                 elem;
            logic signed [`IA_REG_W:0] sum;

            if (cfg_zp_16) begin
                elem = icb_rsp_rdata.s16[i[0]];  // upper lanes masked off below
            end else begin
                elem = {{8{icb_rsp_rdata.s8[i][7]}}, icb_rsp_rdata.s8[i]};
            end
            sum = 33'(elem) + 33'(zp);           // one guard bit, no wrap
            if (sum > MAX16)      wr_data[i] = 16'sh7fff;
            else if (sum < MIN16) wr_data[i] = 16'sh8000;
            else                  wr_data[i] = sum[`IA_DATA_W-1:0];
            wr_mask[i] = (!cfg_zp_16 || i < `IA_BEAT_BYTES / 2) &&
                         ({1'b0, wr_col} + 5'(i) < 5'(`IA_SIZE));
        end
    end

endmodule

`default_nettype wire

// File: logic/tile_row_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module tile_row_buffer
    import ia_loader_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [`IA_SIZE_LOG2-1:0]  wr_row,
    input  logic [`IA_SIZE_LOG2-1:0]  wr_col,
    input  ia_lanes_t                 wr_data,
    input  logic [`IA_BEAT_BYTES-1:0] wr_mask,
    input  logic                      send_start,
    input  tile_info_t                tile_info,
    output ia_row_t                   ia_out,
    output logic                      ia_row_valid,
    output logic                      ia_is_init_data,
    output logic                      ia_calc_done,
    output logic                      ia_sending_done
);

    ia_row_t                mem [`IA_SIZE];
    logic [`IA_SIZE_LOG2:0] send_cnt;  // row on ia_out
    logic                   sending;

    // tile storage, one beat of lanes per write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `IA_BEAT_BYTES; i++) begin
                if (wr_mask[i]) mem[wr_row][wr_col + 4'(i)] <= wr_data[i];
            end
        end
    end

    // ==================================================================
    // play out, one row per cycle, done right after the last row
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sending         <= 1'b0;
            send_cnt        <= '0;
            ia_sending_done <= 1'b0;
        end else begin
            ia_sending_done <= 1'b0;
            if (send_start) begin
                sending  <= 1'b1;
                send_cnt <= '0;
            end else if (sending) begin
                send_cnt <= send_cnt + 1'b1;
                if (send_cnt == tile_info.valid_rows - 1'b1) begin
                    sending         <= 1'b0;
                    ia_sending_done <= 1'b1;
                end
            end
        end
    end

    assign ia_out          = mem[send_cnt[`IA_SIZE_LOG2-1:0]];
    assign ia_row_valid    = sending;
    assign ia_is_init_data = sending && tile_info.first_col;  // tile info holds until done
    assign ia_calc_done    = sending && tile_info.last_col;

endmodule

`default_nettype wire

// File: logic/ia_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module ia_loader
    import ia_loader_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      init_cfg,         // one-cycle pulse
    output logic      load_ia_req,
    input  logic      load_ia_granted,
    input  logic      send_ia_trigger,  // one-cycle pulse
    input  ia_cfg_t   cfg,              // stable while init_cfg is high
    output logic      icb_cmd_valid,
    input  logic      icb_cmd_ready,
    output icb_cmd_t  icb_cmd,
    input  logic      icb_rsp_valid,
    output logic      icb_rsp_ready,
    input  rsp_word_u icb_rsp_rdata,
    output ia_row_t   ia_out,
    output logic      ia_row_valid,
    output logic      ia_is_init_data,
    output logic      ia_calc_done,
    output logic      ia_data_valid,
    output logic      ia_sending_done
);

    tile_info_t                tile_info;
    logic                      idle, load_en, send_start, tile_loaded;
    logic                      wr_en;
    logic [`IA_SIZE_LOG2-1:0]  wr_row, wr_col;
    ia_lanes_t                 wr_data;
    logic [`IA_BEAT_BYTES-1:0] wr_mask;

    ia_loader_fsm u_fsm (
        .clk, .rst_n, .init_cfg, .load_ia_granted, .send_ia_trigger,
        .tile_loaded, .ia_sending_done, .tile_info,
        .idle, .load_ia_req, .load_en, .send_start, .ia_data_valid
    );

    tile_walker u_walker (
        .clk, .rst_n, .init_cfg, .idle, .cfg, .ia_sending_done, .tile_info
    );

    icb_read_master u_rd (
        .clk, .rst_n, .load_en, .tile_info, .icb_cmd_ready, .icb_cmd_valid, .icb_cmd
    );

    // latched width and zero point ride along in tile_info
    rsp_unpacker u_unpack (
        .clk, .rst_n, .load_en,
        .cfg_zp_16 (tile_info.use_16bits),
        .zp        (tile_info.zp),
        .tile_info, .icb_rsp_valid, .icb_rsp_rdata, .icb_rsp_ready,
        .wr_en, .wr_row, .wr_col, .wr_data, .wr_mask, .tile_loaded
    );

    tile_row_buffer u_buf (
        .clk, .rst_n, .wr_en, .wr_row, .wr_col, .wr_data, .wr_mask,
        .send_start, .tile_info,
        .ia_out, .ia_row_valid, .ia_is_init_data, .ia_calc_done, .ia_sending_done
    );

endmodule

`default_nettype wire

// File: dv/icb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module icb_mem_model
    import ia_loader_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      ready_rand,     // random bit, cmd_ready this cycle
    input  logic      valid_rand,     // random bit, beat offered this cycle
    input  logic      icb_cmd_valid,
    output logic      icb_cmd_ready,
    input  icb_cmd_t  icb_cmd,
    output logic      icb_rsp_valid,
    input  logic      icb_rsp_ready,
    output rsp_word_u icb_rsp_rdata
);

    logic [`IA_REG_W-1:0] q_addr [$];  // accepted bursts, in order
    logic [`IA_LEN_W-1:0] q_len  [$];
    int                   beat = 0;
    logic [`IA_REG_W-1:0] a;

    // byte at address A is the low byte of A*7+3
    function automatic logic [7:0] byte_at(input logic [`IA_REG_W-1:0] addr);
        return 8'(addr * 32'd7 + 32'd3);
    endfunction

    always @(posedge clk) begin
        if (icb_cmd_valid && icb_cmd_ready) begin
            q_addr.push_back(icb_cmd.addr);
            q_len.push_back(icb_cmd.len);
        end
        if (icb_rsp_valid && icb_rsp_ready) begin
            if (beat == int'(q_len[0])) begin  // burst complete
                beat = 0;
                void'(q_addr.pop_front());
                void'(q_len.pop_front());
            end else begin
                beat = beat + 1;
            end
        end
    end

    // outputs change on the falling edge only
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            icb_cmd_ready <= 1'b0;
            icb_rsp_valid <= 1'b0;
            icb_rsp_rdata <= '0;
        end else begin
            icb_cmd_ready <= ready_rand;
            if (q_addr.size() > 0 && valid_rand) begin
                a = q_addr[0] + 32'(beat * `IA_BEAT_BYTES);
                icb_rsp_valid <= 1'b1;
                icb_rsp_rdata <= {byte_at(a + 3), byte_at(a + 2), byte_at(a + 1), byte_at(a)};
            end else begin
                icb_rsp_valid <= 1'b0;  // gap
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_ia_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "ia_loader_macros.svh"

module tb_ia_loader
    import ia_loader_pkg::*;
();

    localparam int LIMIT = 12000;  // 4000 cycles per run, three runs

    logic      clk, rst_n, init_cfg, load_ia_granted, send_ia_trigger;
    ia_cfg_t   cfg;
    logic      load_ia_req, icb_cmd_valid, icb_cmd_ready, icb_rsp_valid, icb_rsp_ready;
    icb_cmd_t  icb_cmd;
    rsp_word_u icb_rsp_rdata;
    ia_row_t   ia_out;
    logic      ia_row_valid, ia_is_init_data, ia_calc_done, ia_data_valid, ia_sending_done;

    int                   errors = 0;
    int                   cycles = 0;
    logic [31:0]          lfsr = 32'h316a;
    logic                 rdy_rand, vld_rand;

    // expected tile order and command stream of the current run
    logic [31:0]          t_addr [64];
    int                   t_vr [64];
    int                   t_vc [64];
    logic                 t_first [64];
    logic                 t_last [64];
    int                   n_tiles = 0;
    icb_cmd_t             cmd_exp [1024];
    int                   n_cmds = 0;
    logic [31:0]          run_stride;
    logic                 run_16;
    logic signed [31:0]   run_zp;

    int                   tile_idx, row_idx, cmd_idx, ti;
    int                   cur_vr;
    logic                 cur_first, cur_last;
    ia_row_t              exp_row, exp_mask;
    icb_cmd_t             exp_cmd;

    ia_loader u_ia_loader (.*);

    icb_mem_model u_mem (
        .clk, .rst_n, .ready_rand (rdy_rand), .valid_rand (vld_rand),
        .icb_cmd_valid, .icb_cmd_ready, .icb_cmd,
        .icb_rsp_valid, .icb_rsp_ready, .icb_rsp_rdata
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // galois lfsr, x^32+x^22+x^2+x+1
    function automatic logic rand_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    // bus gap bits, used on the next falling edge
    always @(posedge clk) begin
        rdy_rand <= rand_bit();
        vld_rand <= rand_bit();
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [7:0] mem_byte(input logic [31:0] a);
        return 8'(a * 32'd7 + 32'd3);
    endfunction

    function automatic logic signed [15:0] elem_model(input logic [31:0] a, input logic use16,
                                                      input logic signed [31:0] zp);
        longint v;
        if (use16) v = longint'($signed({mem_byte(a + 1), mem_byte(a)}));
        else       v = longint'($signed(mem_byte(a)));
        v = v + longint'(zp);
        if (v > 32767)       v = 32767;   // saturate high
        else if (v < -32768) v = -32768;
        return 16'(v);
    endfunction

    always_comb begin
        ti        = (tile_idx < 64) ? tile_idx : 0;
        cur_vr    = t_vr[ti];
        cur_first = t_first[ti];
        cur_last  = t_last[ti];
        exp_row   = '0;
        exp_mask  = '0;
        for (int j = 0; j < `IA_SIZE; j++) begin
            if (j < t_vc[ti]) begin  // cols past n are don't care
                exp_row[j]  = elem_model(t_addr[ti] + 32'(row_idx) * run_stride +
                                         32'(j * (run_16 ? 2 : 1)), run_16, run_zp);
                exp_mask[j] = 16'hffff;
            end
        end
        exp_cmd = cmd_exp[(cmd_idx < 1024) ? cmd_idx : 0];
    end

    // position in the expected streams
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tile_idx <= 0;
            row_idx  <= 0;
            cmd_idx  <= 0;
        end else if (init_cfg) begin
            tile_idx <= 0;
            row_idx  <= 0;
            cmd_idx  <= 0;
        end else begin
            if (icb_cmd_valid && icb_cmd_ready) cmd_idx <= cmd_idx + 1;
            if (ia_sending_done) begin
                tile_idx <= tile_idx + 1;
                row_idx  <= 0;
            end else if (ia_row_valid) begin
                row_idx <= row_idx + 1;
            end
        end
    end

    // ======================================================================
    // checks
    // ======================================================================
    a_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        icb_cmd_valid && icb_cmd_ready |-> icb_cmd == exp_cmd)
        else begin
            errors++;
            $display("FAIL icb_cmd got %h expected %h", $sampled(icb_cmd), $sampled(exp_cmd));
        end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid |-> ((ia_out ^ exp_row) & exp_mask) == '0)
        else begin
            errors++;
            $display("FAIL ia_out row %h got %h expected %h (mask %h)", $sampled(row_idx),
                     $sampled(ia_out), $sampled(exp_row), $sampled(exp_mask));
        end

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid |-> ia_is_init_data == cur_first && ia_calc_done == cur_last)
        else begin
            errors++;
            $display("FAIL ia_is_init_data/ia_calc_done got %h/%h expected %h/%h",
                     $sampled(ia_is_init_data), $sampled(ia_calc_done),
                     $sampled(cur_first), $sampled(cur_last));
        end

    a_flags_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !ia_row_valid |-> !ia_is_init_data && !ia_calc_done)
        else begin
            errors++;
            $display("flag raised without a valid row");
        end

    a_rows_run: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid && row_idx < cur_vr - 1 |=> ia_row_valid)
        else begin
            errors++;
            $display("gap inside the rows of a tile");
        end

    a_rows_end: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid && row_idx == cur_vr - 1 |=> !ia_row_valid && ia_sending_done)
        else begin
            errors++;
            $display("tile did not end with ia_sending_done after its last row");
        end

    a_rows_max: assert property (@(posedge clk) disable iff (!rst_n)
        ia_row_valid |-> row_idx < cur_vr)
        else begin
            errors++;
            $display("more rows sent than the tile holds");
        end

    a_trigger: assert property (@(posedge clk) disable iff (!rst_n)
        send_ia_trigger && ia_data_valid |=> ia_row_valid && !ia_data_valid)
        else begin
            errors++;
            $display("trigger taken but rows did not start or ia_data_valid stayed high");
        end

    a_no_stray_rows: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ia_row_valid) |-> $past(send_ia_trigger && ia_data_valid))
        else begin
            errors++;
            $display("rows started without a trigger");
        end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        load_ia_req && !load_ia_granted |=> load_ia_req)
        else begin
            errors++;
            $display("load_ia_req dropped before a grant");
        end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tile_idx == n_tiles |-> !load_ia_req)
        else begin
            errors++;
            $display("load request raised after the last tile");
        end

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic plan_run(input int k, input int n, input int m, input logic [31:0] base,
                            input logic [31:0] stride, input logic use16);
        int          tk, tn, tm, vr, vc, beats;
        logic [31:0] addr;
        tk = (k + `IA_SIZE - 1) / `IA_SIZE;
        tn = (n + `IA_SIZE - 1) / `IA_SIZE;
        tm = (m + `IA_SIZE - 1) / `IA_SIZE;
        n_tiles = 0;
        n_cmds  = 0;
        for (int tr = 0; tr < tk; tr++) begin
            for (int lp = 0; lp < tm; lp++) begin
                for (int tc = 0; tc < tn; tc++) begin
                    addr  = base + 32'(tr * `IA_SIZE) * stride +
                            32'(tc * `IA_SIZE * (use16 ? 2 : 1));
                    vr    = (tr == tk - 1) ? k - tr * `IA_SIZE : `IA_SIZE;
                    vc    = (tc == tn - 1) ? n - tc * `IA_SIZE : `IA_SIZE;
                    // row bytes rounded up to whole bus beats
                    beats = (vc * (use16 ? 2 : 1) + `IA_BEAT_BYTES - 1) / `IA_BEAT_BYTES;
                    t_addr[n_tiles]  = addr;
                    t_vr[n_tiles]    = vr;
                    t_vc[n_tiles]    = vc;
                    t_first[n_tiles] = (tc == 0);
                    t_last[n_tiles]  = (tc == tn - 1);
                    for (int r = 0; r < vr; r++) begin
                        cmd_exp[n_cmds].addr = addr + 32'(r) * stride;
                        cmd_exp[n_cmds].len  = 4'(beats - 1);
                        n_cmds++;
                    end
                    n_tiles++;
                end
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge the signal is seen high
    task automatic wait_high(input int sel);
        while (!(sel == 0 ? load_ia_req : (sel == 1 ? ia_data_valid : ia_sending_done)))
            @(negedge clk);
    endtask

    // 0..3 cycles, two lfsr bits
    task automatic random_wait();
        int d;
        d = int'({rand_bit(), rand_bit()});
        repeat (d) @(negedge clk);
    endtask

    task automatic do_run(input int k, input int n, input int m, input logic [31:0] base,
                          input logic [31:0] stride, input logic use16,
                          input logic signed [31:0] zp);
        plan_run(k, n, m, base, stride, use16);
        run_stride = stride;
        run_16     = use16;
        run_zp     = zp;
        cfg = '{k: k, n: n, m: m, base: base, stride: stride, zp: zp, use_16bits: use16};
        init_cfg = 1'b1;
        @(negedge clk);
        init_cfg = 1'b0;
        for (int t = 0; t < n_tiles; t++) begin
            wait_high(0);
            send_ia_trigger = 1'b1;  // stray trigger, must be ignored
            @(negedge clk);
            send_ia_trigger = 1'b0;
            random_wait();
            load_ia_granted = 1'b1;
            @(negedge clk);
            load_ia_granted = 1'b0;
            wait_high(1);
            random_wait();
            send_ia_trigger = 1'b1;
            @(negedge clk);
            send_ia_trigger = 1'b0;
            wait_high(2);
            @(negedge clk);
        end
        repeat (20) @(negedge clk);  // idle window
        a_tile_count: assert (tile_idx == n_tiles)
            else begin
                errors++;
                $display("FAIL tile_idx got %h expected %h", tile_idx, n_tiles);
            end
    endtask

    initial begin
        rst_n           = 1'b0;
        init_cfg        = 1'b0;
        load_ia_granted = 1'b0;
        send_ia_trigger = 1'b0;
        cfg             = '0;
        run_stride      = '0;
        run_16          = 1'b0;
        run_zp          = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        a_reset_low: assert (!(load_ia_req || icb_cmd_valid || icb_rsp_ready ||
                               ia_row_valid || ia_data_valid || ia_sending_done))
            else begin
                errors++;
                $display({"FAIL {load_ia_req,icb_cmd_valid,icb_rsp_ready,ia_row_valid,",
                          "ia_data_valid,ia_sending_done} got %h expected 00"},
                         {load_ia_req, icb_cmd_valid, icb_rsp_ready, ia_row_valid,
                          ia_data_valid, ia_sending_done});
            end
        do_run(18, 20, 17, 32'h100, 32'd64, 1'b0, -32'sd200);
        do_run(5, 9, 3, 32'h800, 32'd40, 1'b1, 32'sd32760);
        // negative s16 values clip at the bottom
        do_run(3, 6, 1, 32'h400, 32'd24, 1'b1, -32'sd32760);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles, errors: %0d", cycles, errors);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+logic
logic/ia_loader_pkg.sv
logic/ia_loader_fsm.sv
logic/tile_walker.sv
logic/icb_read_master.sv
logic/rsp_unpacker.sv
logic/tile_row_buffer.sv
logic/ia_loader.sv
dv/icb_mem_model.sv
dv/tb_ia_loader.sv

// File: run.sh
#!/bin/sh
# build and run the ia_loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ia_loader \
    -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ia_loader > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0
